// ==== src/ranging_pkg.sv ====
package ranging_pkg;

  // coarse flight time, counted in clk cycles
  typedef logic [15:0] flight_t;

  // scan position of a shot
  typedef logic [7:0] pixel_t;
  typedef logic [7:0] line_t;

  // one tagged measurement, 32 bits
  // sent msb first, so line goes out first on the serial line
  typedef struct packed {
    line_t   line;
    pixel_t  pixel;
    flight_t flight;
  } range_result_t;

  // reported when no stop pulse came back in time
  localparam flight_t FLIGHT_TIMEOUT_CODE = '1;

  // 64 MHz core clock / 4 Mbaud
  localparam int DEF_BAUD_DIV = 16;

  // roughly 12.6 kHz shot rate at 64 MHz
  localparam int DEF_SHOT_DIV = 5064;

  // longest wait for the stop pulse, in clk edges
  localparam int DEF_STOP_TIMEOUT = 4096;

  // result slots, also the number of shot credits
  localparam int DEF_FIFO_DEPTH = 64;

  // pixels before the line index steps
  localparam int DEF_PIXELS_PER_LINE = 240;

endpackage

// ==== src/shot_control.sv ====
`timescale 1ns/1ps

module shot_control import ranging_pkg::*; #(
  parameter int SHOT_DIV        = DEF_SHOT_DIV,
  parameter int STOP_TIMEOUT    = DEF_STOP_TIMEOUT,
  parameter int FIFO_DEPTH      = DEF_FIFO_DEPTH,
  parameter int PIXELS_PER_LINE = DEF_PIXELS_PER_LINE
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          pause,
  input  logic          tdc_stop,
  input  logic          credit_return,
  output logic          tdc_start,
  output logic          push,
  output range_result_t push_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_REPORT
  } state_t;

  localparam int PER_W  = $clog2(SHOT_DIV + 1);
  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  // period counter saturates here, one edge before the next start is allowed
  localparam logic [PER_W-1:0]  PER_LAST   = PER_W'(SHOT_DIV - 1);
  localparam logic [CRED_W-1:0] CRED_FULL  = CRED_W'(FIFO_DEPTH);
  localparam pixel_t            PIXEL_LAST = pixel_t'(PIXELS_PER_LINE - 1);
  localparam flight_t           WAIT_LAST  = flight_t'(STOP_TIMEOUT);

  state_t            state;
  logic [PER_W-1:0]  per_cnt;
  logic [CRED_W-1:0] credits;
  flight_t           flight_cnt;
  flight_t           flight_next;
  flight_t           flight_q;
  pixel_t            pixel_idx;
  line_t             line_idx;
  logic              fire;

  // edges seen since the start edge, including this one
  assign flight_next = flight_cnt + 16'd1;

  // start only from idle, after a full period, unpaused and with a free slot
  assign fire = (state == ST_IDLE) && (per_cnt == PER_LAST) && !pause && (credits != '0);

  // one result per trip through report
  assign push = (state == ST_REPORT);
  assign push_data = '{line: line_idx, pixel: pixel_idx, flight: flight_q};

  // shot period, restarted by every start edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      per_cnt <= '0;
    end else if (fire) begin
      per_cnt <= '0;
    end else if (per_cnt != PER_LAST) begin
      per_cnt <= per_cnt + 1'b1;
    end
  end

  // shot fsm
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      tdc_start <= 1'b0;
    end else begin
      tdc_start <= fire;
      case (state)
        ST_IDLE: begin
          if (fire) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          // stop wins over timeout on the last edge of the window
          if (tdc_stop || flight_next == WAIT_LAST) begin
            state <= ST_REPORT;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // flight count runs only while waiting
  always_ff @(posedge clk) begin
    if (state == ST_WAIT) begin
      flight_cnt <= flight_next;
      flight_q   <= tdc_stop ? flight_next : FLIGHT_TIMEOUT_CODE;
    end else begin
      flight_cnt <= '0;
    end
  end

  // scan position, stepped after each reported shot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pixel_idx <= '0;
      line_idx  <= '0;
    end else if (push) begin
      if (pixel_idx == PIXEL_LAST) begin
        pixel_idx <= '0;
        // line wraps at 256 by width
        line_idx  <= line_idx + 8'd1;
      end else begin
        pixel_idx <= pixel_idx + 8'd1;
      end
    end
  end

  // one credit per fifo slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= CRED_FULL;
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // fifo never hands back more credits than it has slots
  a_credit_max : assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CRED_FULL)
    else $error("shot_control: credits above fifo depth");

  // credit taken at start must still be there at push
  a_push_credit : assert property (@(posedge clk) disable iff (!rst_n)
    push |-> credits != '0)
    else $error("shot_control: push without credit");

endmodule

// ==== src/result_fifo.sv ====
`timescale 1ns/1ps

module result_fifo import ranging_pkg::*; #(
  parameter type payload_t  = range_result_t,
  parameter int  FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     credit_return
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full  = (count == CNT_FULL);
  assign empty = (count == '0);

  // guarded strobes keep pointers sane if a caller misbehaves
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // first word fall through
  assign head = mem[rd_ptr];

  // every pop frees a slot for the producer
  assign credit_return = do_pop;

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap at depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // credit scheme upstream should make this impossible
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full)
    else $error("result_fifo: push while full");

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty)
    else $error("result_fifo: pop while empty");

endmodule

// ==== src/serial_result_tx.sv ====
`timescale 1ns/1ps

module serial_result_tx import ranging_pkg::*; #(
  parameter int BAUD_DIV = DEF_BAUD_DIV
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          empty,
  input  range_result_t head,
  output logic          pop,
  output logic          serial_out
);

  localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);

  logic              busy;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;
  logic [1:0]        byte_cnt;
  // lower three bytes of the result, next byte on top
  logic [23:0]       word_q;
  // stop, 8 data lsb first, start; shifted out from bit 0
  logic [9:0]        frame_q;
  logic              bit_end;
  logic              byte_end;

  // take the next result as soon as the line is free
  assign pop = !busy && !empty;

  assign bit_end  = busy && (baud_cnt == BAUD_LAST);
  assign byte_end = bit_end && (bit_cnt == 4'd9);

  // line rests high between results
  assign serial_out = busy ? frame_q[0] : 1'b1;

  // baud, bit and byte counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
    end else if (pop) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
    end else if (busy) begin
      baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
      if (byte_end) begin
        bit_cnt  <= '0;
        // wraps to 0 after the fourth byte
        byte_cnt <= byte_cnt + 2'd1;
        if (byte_cnt == 2'd3) begin
          busy <= 1'b0;
        end
      end else if (bit_end) begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
  end

  // remaining bytes and current byte frame
  always_ff @(posedge clk) begin
    if (pop) begin
      word_q  <= head[23:0];
      // msb byte first
      frame_q <= {1'b1, head[31:24], 1'b0};
    end else if (byte_end) begin
      word_q  <= {word_q[15:0], 8'h00};
      frame_q <= {1'b1, word_q[23:16], 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

  // every result ends on a stop bit and the line stays high after it
  a_idle_high : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> $past(serial_out) && serial_out)
    else $error("serial_result_tx: line not high at end of result");

endmodule

// ==== src/ranging_top.sv ====
`timescale 1ns/1ps

module ranging_top import ranging_pkg::*; #(
  parameter int BAUD_DIV        = DEF_BAUD_DIV,
  parameter int SHOT_DIV        = DEF_SHOT_DIV,
  parameter int STOP_TIMEOUT    = DEF_STOP_TIMEOUT,
  parameter int FIFO_DEPTH      = DEF_FIFO_DEPTH,
  parameter int PIXELS_PER_LINE = DEF_PIXELS_PER_LINE
) (
  input  logic clk,
  input  logic rst_n,
  input  logic pause,
  input  logic tdc_stop,
  output logic tdc_start,
  output logic serial_out
);

  // producer to buffer
  logic          push;
  range_result_t push_data;
  logic          credit_return;

  // buffer to consumer
  logic          pop;
  logic          empty;
  range_result_t head;

  // shots, flight time and scan tag
  shot_control #(
    .SHOT_DIV        (SHOT_DIV),
    .STOP_TIMEOUT    (STOP_TIMEOUT),
    .FIFO_DEPTH      (FIFO_DEPTH),
    .PIXELS_PER_LINE (PIXELS_PER_LINE)
  ) u_shot (
    .clk           (clk),
    .rst_n         (rst_n),
    .pause         (pause),
    .tdc_stop      (tdc_stop),
    .credit_return (credit_return),
    .tdc_start     (tdc_start),
    .push          (push),
    .push_data     (push_data)
  );

  // result buffer, credits go back on pop
  result_fifo #(
    .payload_t  (range_result_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .push          (push),
    .push_data     (push_data),
    .pop           (pop),
    .head          (head),
    .empty         (empty),
    .credit_return (credit_return)
  );

  // four 8n1 bytes per result
  serial_result_tx #(
    .BAUD_DIV (BAUD_DIV)
  ) u_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .empty      (empty),
    .head       (head),
    .pop        (pop),
    .serial_out (serial_out)
  );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real CLK_PERIOD   = 10.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2.0) clk = ~clk;
  end

  // sync reset, released 1 ns after the last reset edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== bench/tb_ranging.sv ====
`timescale 1ns/1ps

module tb_ranging import ranging_pkg::*; ();

  localparam int BAUD_DIV        = 4;
  localparam int SHOT_DIV        = 64;
  localparam int STOP_TIMEOUT    = 40;
  localparam int FIFO_DEPTH      = 4;
  localparam int PIXELS_PER_LINE = 3;

  localparam int NUM_ENTRIES    = 12;
  localparam int FRAME_CYCLES   = 40 * BAUD_DIV;
  localparam int PAUSE_CYCLES   = 200;
  localparam int TIMEOUT_CYCLES =
    2 * NUM_ENTRIES * (SHOT_DIV + STOP_TIMEOUT + FRAME_CYCLES) + 100;
  localparam int RAND           = -1;
  localparam int DRIVE_DLY      = 1;
  localparam logic [15:0] NO_STOP_FLIGHT = 16'hffff;

  // one table row: stimulus plus the result it must produce
  typedef struct packed {
    logic [7:0]    stop_delay;
    logic          pause_before;
    range_result_t exp;
  } stim_entry_t;

  logic clk;
  logic rst_n;
  logic pause;
  logic tdc_stop;
  logic tdc_start;
  logic serial_out;

  stim_entry_t stim_table [NUM_ENTRIES];
  logic [31:0] rng_state = 32'ha514c998;
  int          errors = 0;
  int          rx_count = 0;
  int          starts_seen = 0;
  int          last_start_cycle = 0;
  int          cycle_cnt = 0;
  logic        start_prev = 1'b0;

  tb_clock_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ranging_top #(
    .BAUD_DIV        (BAUD_DIV),
    .SHOT_DIV        (SHOT_DIV),
    .STOP_TIMEOUT    (STOP_TIMEOUT),
    .FIFO_DEPTH      (FIFO_DEPTH),
    .PIXELS_PER_LINE (PIXELS_PER_LINE)
  ) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .pause      (pause),
    .tdc_stop   (tdc_stop),
    .tdc_start  (tdc_start),
    .serial_out (serial_out)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("** Error %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("failure at %0t: %s", $time, msg);
    errors++;
  endtask

  // delay < 0 draws 1..39 from the generator
  task automatic set_entry(input int idx, input int delay, input logic pause_flag);
    int d;
    d = delay;
    if (d < 0) begin
      rng_state = xorshift32(rng_state);
      d = 1 + int'(rng_state % 32'd39);
    end
    stim_table[idx].stop_delay   = 8'(d);
    stim_table[idx].pause_before = pause_flag;
    stim_table[idx].exp.flight   = (d == 0) ? NO_STOP_FLIGHT : 16'(d);
    // scan position follows shot order
    stim_table[idx].exp.pixel    = 8'(idx % PIXELS_PER_LINE);
    stim_table[idx].exp.line     = 8'(idx / PIXELS_PER_LINE);
  endtask

  task automatic fill_table();
    // earliest stop edge
    set_entry(0, 1, 1'b0);
    // last edge inside the window
    set_entry(1, STOP_TIMEOUT, 1'b0);
    // no stop at all
    set_entry(2, 0, 1'b0);
    set_entry(3, RAND, 1'b0);
    set_entry(4, RAND, 1'b0);
    set_entry(5, RAND, 1'b0);
    // long pause ahead of this shot
    set_entry(6, RAND, 1'b1);
    set_entry(7, RAND, 1'b0);
    set_entry(8, 0, 1'b0);
    set_entry(9, 12, 1'b0);
    set_entry(10, RAND, 1'b0);
    set_entry(11, RAND, 1'b0);
  endtask

  // outputs are settled 1 ns after the edge, inputs change there too
  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic check_startup();
    repeat (SHOT_DIV - 1) begin
      next_cycle();
      if (tdc_start !== 1'b0) report_mismatch("tdc_start after reset", 0, tdc_start);
      if (serial_out !== 1'b1) report_mismatch("serial_out after reset", 1, serial_out);
    end
  endtask

  task automatic wait_for_start();
    do begin
      next_cycle();
    end while (tdc_start !== 1'b1);
  endtask

  // stop sampled on edge number 'delay' after the start edge
  task automatic drive_stop(input int delay);
    repeat (delay - 1) next_cycle();
    tdc_stop = 1'b1;
    next_cycle();
    tdc_stop = 1'b0;
  endtask

  task automatic hold_pause();
    pause = 1'b1;
    repeat (PAUSE_CYCLES) begin
      next_cycle();
      if (tdc_start !== 1'b0) report_mismatch("tdc_start during pause", 0, tdc_start);
    end
    pause = 1'b0;
  endtask

  // nothing may move once the table is done and shots are held
  task automatic check_quiet_line(input int cycles);
    repeat (cycles) begin
      next_cycle();
      if (serial_out !== 1'b1) report_mismatch("serial_out when idle", 1, serial_out);
      if (tdc_start !== 1'b0) report_mismatch("tdc_start when held", 0, tdc_start);
    end
  endtask

  // 8N1 byte, sampled mid bit
  task automatic receive_byte(output logic [7:0] data);
    do begin
      next_cycle();
    end while (serial_out !== 1'b0);
    repeat (BAUD_DIV / 2) next_cycle();
    if (serial_out !== 1'b0) report_failure("start bit on serial_out shorter than half a bit");
    for (int k = 0; k < 8; k++) begin
      repeat (BAUD_DIV) next_cycle();
      data[k] = serial_out;
    end
    repeat (BAUD_DIV) next_cycle();
    if (serial_out !== 1'b1) report_mismatch("serial_out stop bit", 1, serial_out);
  endtask

  task automatic check_result(input logic [31:0] word);
    range_result_t got;
    range_result_t exp;
    got = word;
    if (rx_count >= NUM_ENTRIES) begin
      report_failure("result received beyond the end of the table");
    end else begin
      exp = stim_table[rx_count].exp;
      if (got.flight !== exp.flight)
        report_mismatch($sformatf("result[%0d].flight", rx_count), exp.flight, got.flight);
      if (got.pixel !== exp.pixel)
        report_mismatch($sformatf("result[%0d].pixel", rx_count), exp.pixel, got.pixel);
      if (got.line !== exp.line)
        report_mismatch($sformatf("result[%0d].line", rx_count), exp.line, got.line);
    end
    rx_count++;
  endtask

  // serial decoder, msb byte first
  initial begin
    logic [7:0]  rx_byte;
    logic [31:0] word;
    wait (rst_n === 1'b1);
    forever begin
      for (int b = 0; b < 4; b++) begin
        receive_byte(rx_byte);
        word = {word[23:0], rx_byte};
      end
      check_result(word);
    end
  end

  // start pulse width and spacing, sampled away from the rising edge
  always @(negedge clk) begin
    if (rst_n === 1'b1 && tdc_start === 1'b1) begin
      if (start_prev === 1'b1) begin
        report_failure("tdc_start high for more than one cycle");
      end else begin
        if (starts_seen > 0 && cycle_cnt - last_start_cycle < SHOT_DIV)
          report_mismatch("tdc_start spacing (minimum)", SHOT_DIV,
                          cycle_cnt - last_start_cycle);
        last_start_cycle = cycle_cnt;
        starts_seen++;
      end
    end
    start_prev = tdc_start;
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d results received, %0d errors",
               cycle_cnt, rx_count, NUM_ENTRIES, errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // stop-pulse model, one table row per start pulse
  initial begin
    pause    = 1'b0;
    tdc_stop = 1'b0;
    fill_table();
    wait (rst_n === 1'b1);
    check_startup();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (stim_table[i].pause_before) hold_pause();
      wait_for_start();
      if (stim_table[i].stop_delay != 0) drive_stop(stim_table[i].stop_delay);
    end
    // shots are periodic, so hold the next one
    pause = 1'b1;
    while (rx_count < NUM_ENTRIES) next_cycle();
    check_quiet_line(2 * FRAME_CYCLES);
    if (starts_seen != NUM_ENTRIES)
      report_failure($sformatf("saw %0d start pulses for %0d table rows",
                               starts_seen, NUM_ENTRIES));
    $display("tb_ranging: %0d errors, %0d results received, %0d start pulses",
             errors, rx_count, starts_seen);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/ranging_pkg.sv
src/shot_control.sv
src/result_fifo.sv
src/serial_result_tx.sv
src/ranging_top.sv
bench/tb_clock_gen.sv
bench/tb_ranging.sv

// ==== Bender.yml ====
package:
  name: laser_ranging_channel

sources:
  - files:
      - src/ranging_pkg.sv
      - src/shot_control.sv
      - src/result_fifo.sv
      - src/serial_result_tx.sv
      - src/ranging_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_ranging.sv
